//--- files.f
+incdir+verilog
verilog/soc_pkg.sv
verilog/sba_port.sv
verilog/soc_router.sv
verilog/l2_sram.sv
verilog/ctrl_regs.sv
verilog/ara_soc_lite.sv
verification/soc_checker.sv
verification/tb_ara_soc_lite.sv

//--- Bender.yml
package:
  name: ara_soc_lite

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/soc_pkg.sv
      - verilog/sba_port.sv
      - verilog/soc_router.sv
      - verilog/l2_sram.sv
      - verilog/ctrl_regs.sv
      - verilog/ara_soc_lite.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/soc_checker.sv
      - verification/tb_ara_soc_lite.sv

//--- verification/tb_ara_soc_lite.sv
// Testbench for the SBA memory subsystem.
// Drives random single-beat SBA accesses into every window, plays the
// external debug module on the debug window port, and lets soc_checker
// compare the DUT against its model. Run through files.f.

`timescale 1ns/1ps
`include "soc_settings.svh"

module tb_ara_soc_lite;

  logic               clk_i;
  logic               rst_ni;
  logic               sba_req, sba_we, sba_gnt, sba_r_valid;
  soc_pkg::soc_addr_t sba_addr, dm_addr;
  soc_pkg::soc_strb_t sba_be, dm_be;
  soc_pkg::soc_data_t sba_wdata, sba_r_rdata;
  logic               dm_req, dm_we;
  soc_pkg::soc_data_t dm_wdata, dm_rdata, exit_val, cnt_en;

  soc_pkg::soc_data_t dbg_mem [`DBG_LEN/8];
  soc_pkg::soc_data_t dbg_rdata;
  int unsigned        dbg_idx;
  int                 seed = 35;
  int                 test_tmo = 0;
  int                 timeouts = 0;

  ara_soc_lite dut (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .sba_req_i(sba_req), .sba_we_i(sba_we), .sba_addr_i(sba_addr), .sba_be_i(sba_be),
    .sba_wdata_i(sba_wdata), .sba_gnt_o(sba_gnt), .sba_r_valid_o(sba_r_valid),
    .sba_r_rdata_o(sba_r_rdata),
    .dm_device_req_o(dm_req), .dm_device_we_o(dm_we), .dm_device_addr_o(dm_addr),
    .dm_device_be_o(dm_be), .dm_device_wdata_o(dm_wdata), .dm_device_rdata_i(dm_rdata),
    .exit_o(exit_val), .hw_cnt_en_o(cnt_en)
  );

  soc_checker u_check (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .sba_req_i(sba_req), .sba_we_i(sba_we), .sba_addr_i(sba_addr), .sba_be_i(sba_be),
    .sba_wdata_i(sba_wdata), .sba_gnt_i(sba_gnt), .sba_r_valid_i(sba_r_valid),
    .sba_r_rdata_i(sba_r_rdata),
    .dm_device_req_i(dm_req), .dm_device_we_i(dm_we), .dm_device_addr_i(dm_addr),
    .dm_device_be_i(dm_be), .dm_device_wdata_i(dm_wdata),
    .exit_i(exit_val), .hw_cnt_en_i(cnt_en)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // External debug module memory
  ////////////////////////////////////////

  // Writes land at once and read data follows one cycle later
  always begin
    @(negedge clk_i);
    if (dm_req) begin
      dbg_idx = (dm_addr - `DBG_BASE) >> 3;
      if (dm_we) begin
        for (int b = 0; b < `SOC_STRB_W; b++) begin
          if (dm_be[b]) dbg_mem[dbg_idx][8*b +: 8] = dm_wdata[8*b +: 8];
        end
      end else begin
        dbg_rdata = dbg_mem[dbg_idx];
        @(posedge clk_i);
        #5;
        dm_rdata = dbg_rdata;
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic soc_pkg::soc_data_t rand_data();
    logic [31:0] hi, lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  // Window 0 L2, 1 control registers, 2 debug (first 16 words), 3 unmapped
  function automatic soc_pkg::soc_addr_t pick_addr(input int win);
    int unsigned sel, r;
    sel = $random(seed);
    r = $random(seed);
    case (win)
      0: return `L2_BASE + (r % `L2_WORDS) * 8;
      1: return (sel % 4 < 2) ? `CTRL_BASE + (sel % 2) * 8 : `CTRL_BASE + (r % 510 + 2) * 8;
      2: return `DBG_BASE + (r % 16) * 8;
      default: begin
        case (sel % 4)
          0: return 32'h0000_0000 + (r % 64) * 8;
          1: return 32'h4000_0000 + (r % 64) * 8;
          2: return `L2_BASE + `L2_LEN + (r % 64) * 8;
          default: return `CTRL_BASE + `CTRL_LEN + (r % 64) * 8;
        endcase
      end
    endcase
  endfunction

  // Runs one SBA access and with hold keeps the request line up while busy
  task automatic sba_access(input logic we, input soc_pkg::soc_addr_t addr,
                            input soc_pkg::soc_strb_t be, input soc_pkg::soc_data_t wdata,
                            input logic hold);
    logic granted, done;
    granted = 1'b0;
    done = 1'b0;
    @(posedge clk_i);
    #5;
    sba_req = 1'b1;
    sba_we = we;
    sba_addr = addr;
    sba_be = be;
    sba_wdata = wdata;
    for (int w = 0; w < 20 && !granted; w++) begin
      @(negedge clk_i);
      granted = sba_gnt;
    end
    @(posedge clk_i);
    #5;
    if (!granted) begin
      $display("Timeout at %0t ns: no SBA grant within 20 cycles for %h", $time, addr);
      test_tmo++;
      sba_req = 1'b0;
    end else begin
      if (hold) begin
        // Payload changes must not reach the latched request
        sba_addr = addr ^ 32'h8;
        sba_wdata = ~wdata;
      end else begin
        sba_req = 1'b0;
      end
      for (int w = 0; w < 20 && !done; w++) begin
        @(negedge clk_i);
        done = sba_r_valid;
      end
      if (!done) begin
        $display("Timeout at %0t ns: no SBA response within 20 cycles for %h", $time, addr);
        test_tmo++;
      end
      if (hold) begin
        @(posedge clk_i);
        #5;
        sba_req = 1'b0;
      end
    end
  endtask

  task automatic random_ops(input int win, input int count, input logic hold);
    int    w;
    logic  we;
    logic [31:0] rnd;
    soc_pkg::soc_strb_t be;
    for (int n = 0; n < count; n++) begin
      w = (win < 0) ? $unsigned($random(seed)) % 3 : win;
      rnd = $random(seed);
      we = rnd[0];
      rnd = $random(seed);
      be = rnd[`SOC_STRB_W-1:0];
      sba_access(we, pick_addr(w), be, rand_data(), hold);
    end
  endtask

  task automatic finish_test(input string name);
    repeat (2) @(posedge clk_i);
    u_check.end_test(name, test_tmo);
    timeouts += test_tmo;
    test_tmo = 0;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    rst_ni = 1'b0;
    sba_req = 1'b0;
    sba_we = 1'b0;
    sba_addr = '0;
    sba_be = '0;
    sba_wdata = '0;
    dm_rdata = '0;
    repeat (16) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    repeat (4) @(posedge clk_i);
    finish_test("reset");

    // Every L2 word gets a full write first
    for (int i = 0; i < `L2_WORDS; i++) begin
      sba_access(1'b1, `L2_BASE + i * 8, 8'hff, rand_data(), 1'b0);
    end
    random_ops(0, 60, 1'b0);
    finish_test("l2");

    random_ops(1, 40, 1'b0);
    sba_access(1'b0, `CTRL_BASE, '0, '0, 1'b0);
    sba_access(1'b0, `CTRL_BASE + 8, '0, '0, 1'b0);
    finish_test("ctrl");

    for (int i = 0; i < 16; i++) begin
      sba_access(1'b1, `DBG_BASE + i * 8, 8'hff, rand_data(), 1'b0);
    end
    random_ops(2, 40, 1'b0);
    finish_test("debug");

    random_ops(3, 30, 1'b0);
    for (int i = 0; i < 12; i++) begin
      sba_access(1'b0, pick_addr(i % 3), '0, '0, 1'b0);
    end
    finish_test("unmapped");

    random_ops(-1, 40, 1'b1);
    finish_test("timing");

    $display("Totals: %0d responses, %0d errors, %0d timeouts",
             u_check.rsp_total, u_check.err_total, timeouts);
    if (u_check.err_total == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- verification/soc_checker.sv
// Scoreboard for the SBA subsystem testbench.
// Samples the DUT ports at the falling clock edge, keeps its own model of
// the L2, the control registers and the debug memory, and counts mismatches.
// The testbench top calls end_test after each test for a one-line summary.

`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_checker (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               sba_req_i,
  input logic               sba_we_i,
  input soc_pkg::soc_addr_t sba_addr_i,
  input soc_pkg::soc_strb_t sba_be_i,
  input soc_pkg::soc_data_t sba_wdata_i,
  input logic               sba_gnt_i,
  input logic               sba_r_valid_i,
  input soc_pkg::soc_data_t sba_r_rdata_i,
  input logic               dm_device_req_i,
  input logic               dm_device_we_i,
  input soc_pkg::soc_addr_t dm_device_addr_i,
  input soc_pkg::soc_strb_t dm_device_be_i,
  input soc_pkg::soc_data_t dm_device_wdata_i,
  input soc_pkg::soc_data_t exit_i,
  input soc_pkg::soc_data_t hw_cnt_en_i
);

  soc_pkg::soc_data_t l2_m [`L2_WORDS];
  soc_pkg::soc_data_t dbg_m [`DBG_LEN/8];
  soc_pkg::soc_data_t exit_m = '0;
  soc_pkg::soc_data_t cnt_m = '0;
  soc_pkg::soc_req_t  pend = '0;
  logic               busy;
  int                 cyc = 0;
  int                 pend_cyc = 0;
  int                 err_cnt = 0;
  int                 rsp_cnt = 0;
  int                 err_total = 0;
  int                 rsp_total = 0;

  task automatic report_mismatch(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  function automatic logic in_win(input soc_pkg::soc_addr_t a, input soc_pkg::soc_addr_t base,
                                  input soc_pkg::soc_addr_t len);
    return (a >= base) && (a < base + len);
  endfunction

  // Byte lanes with a set enable take the new data
  function automatic soc_pkg::soc_data_t apply_strobes(input soc_pkg::soc_data_t cur,
                                                       input soc_pkg::soc_data_t wr,
                                                       input soc_pkg::soc_strb_t be);
    soc_pkg::soc_data_t mask;
    for (int b = 0; b < `SOC_STRB_W; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return (cur & ~mask) | (wr & mask);
  endfunction

  // Completes the pending access in the model and checks its read data
  task automatic close_access();
    soc_pkg::soc_data_t exp;
    soc_pkg::soc_addr_t off;
    exp = '0;
    if (in_win(pend.addr, `L2_BASE, `L2_LEN)) begin
      off = (pend.addr - `L2_BASE) >> 3;
      if (pend.we) l2_m[off] = apply_strobes(l2_m[off], pend.wdata, pend.be);
      else exp = l2_m[off];
    end else if (in_win(pend.addr, `CTRL_BASE, `CTRL_LEN)) begin
      off = pend.addr - `CTRL_BASE;
      if (off == 'h0 && pend.we) exit_m = apply_strobes(exit_m, pend.wdata, pend.be);
      else if (off == 'h0) exp = exit_m;
      else if (off == 'h8 && pend.we) cnt_m = apply_strobes(cnt_m, pend.wdata, pend.be);
      else if (off == 'h8) exp = cnt_m;
    end else if (in_win(pend.addr, `DBG_BASE, `DBG_LEN)) begin
      off = (pend.addr - `DBG_BASE) >> 3;
      if (pend.we) dbg_m[off] = apply_strobes(dbg_m[off], pend.wdata, pend.be);
      else exp = dbg_m[off];
    end
    if (sba_r_rdata_i !== exp) begin
      report_mismatch($sformatf("rdata %h for %s at %h, expected %h", sba_r_rdata_i,
                                pend.we ? "write" : "read", pend.addr, exp));
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_ni) begin
      cyc++;
      busy = pend.valid;
      if (sba_gnt_i && !sba_req_i) report_mismatch("grant without a request");
      if (sba_gnt_i && sba_req_i && busy) report_mismatch("grant while busy");
      // Debug window request belongs to the cycle after the grant
      if (dm_device_req_i) begin
        if (!(busy && cyc == pend_cyc + 1 && in_win(pend.addr, `DBG_BASE, `DBG_LEN))) begin
          report_mismatch("unexpected debug window request");
        end else if (dm_device_we_i !== pend.we || dm_device_addr_i !== pend.addr ||
                     dm_device_be_i !== pend.be || dm_device_wdata_i !== pend.wdata) begin
          report_mismatch($sformatf("debug window fields differ for %h", pend.addr));
        end
      end else if (busy && cyc == pend_cyc + 1 && in_win(pend.addr, `DBG_BASE, `DBG_LEN)) begin
        report_mismatch("missing debug window request");
      end
      if (sba_r_valid_i) begin
        if (!busy) begin
          report_mismatch("response without a request");
        end else begin
          if (cyc != pend_cyc + 2) begin
            report_mismatch($sformatf("response %0d cycles after grant", cyc - pend_cyc));
          end
          close_access();
          rsp_cnt++;
        end
        pend.valid = 1'b0;
      end else if (busy && cyc >= pend_cyc + 2) begin
        report_mismatch("no response 2 cycles after grant");
        pend.valid = 1'b0;
      end
      if (sba_gnt_i && sba_req_i && !busy) begin
        pend.valid = 1'b1;
        pend.we    = sba_we_i;
        pend.addr  = sba_addr_i;
        pend.be    = sba_be_i;
        pend.wdata = sba_wdata_i;
        pend_cyc   = cyc;
      end
      if (exit_i !== exit_m) report_mismatch($sformatf("exit_o %h, expected %h", exit_i, exit_m));
      if (hw_cnt_en_i !== cnt_m) begin
        report_mismatch($sformatf("hw_cnt_en_o %h, expected %h", hw_cnt_en_i, cnt_m));
      end
    end
  end

  task automatic end_test(input string name, input int tmo);
    $display("Test %-9s %s: %0d responses, %0d errors, %0d timeouts", name,
             (err_cnt + tmo == 0) ? "passed" : "failed", rsp_cnt, err_cnt, tmo);
    rsp_total += rsp_cnt;
    err_total += err_cnt;
    rsp_cnt = 0;
    err_cnt = 0;
  endtask

endmodule

//--- verilog/ara_soc_lite.sv
// Top level of the SBA memory subsystem.
// The external debug module reaches the L2, the control registers and
// its own memory window through the SBA port while the core is held off.

`timescale 1ns/1ps
`include "soc_settings.svh"

module ara_soc_lite (
  input  logic               clk_i,
  input  logic               rst_ni,
  // SBA from the external debug module
  input  logic               sba_req_i,
  input  logic               sba_we_i,
  input  soc_pkg::soc_addr_t sba_addr_i,
  input  soc_pkg::soc_strb_t sba_be_i,
  input  soc_pkg::soc_data_t sba_wdata_i,
  output logic               sba_gnt_o,
  output logic               sba_r_valid_o,
  output soc_pkg::soc_data_t sba_r_rdata_o,
  // Debug window to the external debug module
  output logic               dm_device_req_o,
  output logic               dm_device_we_o,
  output soc_pkg::soc_addr_t dm_device_addr_o,
  output soc_pkg::soc_strb_t dm_device_be_o,
  output soc_pkg::soc_data_t dm_device_wdata_o,
  input  soc_pkg::soc_data_t dm_device_rdata_i,
  // Control register outputs
  output soc_pkg::soc_data_t exit_o,
  output soc_pkg::soc_data_t hw_cnt_en_o
);

  soc_pkg::soc_req_t bus_req, l2_req, ctrl_req;
  soc_pkg::soc_rsp_t bus_rsp, l2_rsp, ctrl_rsp;

  sba_port i_sba_port (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sba_req_i    (sba_req_i),
    .sba_we_i     (sba_we_i),
    .sba_addr_i   (sba_addr_i),
    .sba_be_i     (sba_be_i),
    .sba_wdata_i  (sba_wdata_i),
    .sba_gnt_o    (sba_gnt_o),
    .sba_r_valid_o(sba_r_valid_o),
    .sba_r_rdata_o(sba_r_rdata_o),
    .bus_req_o    (bus_req),
    .bus_rsp_i    (bus_rsp)
  );

  soc_router i_soc_router (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bus_req_i        (bus_req),
    .bus_rsp_o        (bus_rsp),
    .l2_req_o         (l2_req),
    .ctrl_req_o       (ctrl_req),
    .l2_rsp_i         (l2_rsp),
    .ctrl_rsp_i       (ctrl_rsp),
    .dm_device_req_o  (dm_device_req_o),
    .dm_device_we_o   (dm_device_we_o),
    .dm_device_addr_o (dm_device_addr_o),
    .dm_device_be_o   (dm_device_be_o),
    .dm_device_wdata_o(dm_device_wdata_o),
    .dm_device_rdata_i(dm_device_rdata_i)
  );

  l2_sram i_l2_sram (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .req_i (l2_req),
    .rsp_o (l2_rsp)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (ctrl_req),
    .rsp_o      (ctrl_rsp),
    .exit_o     (exit_o),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

endmodule

//--- verilog/ctrl_regs.sv
// Control registers of the SoC.
// Offset 0x0 holds the exit register, offset 0x8 the counter enables.
// Both are byte-writable and readable; other offsets read zero and
// ignore writes. Responses come one cycle after the request.

`timescale 1ns/1ps
`include "soc_settings.svh"

module ctrl_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  soc_pkg::soc_req_t  req_i,
  output soc_pkg::soc_rsp_t  rsp_o,
  output soc_pkg::soc_data_t exit_o,
  output soc_pkg::soc_data_t hw_cnt_en_o
);

  localparam int unsigned OFF_W = $clog2(`CTRL_LEN);
  localparam logic [OFF_W-1:0] EXIT_OFF   = 'h0;
  localparam logic [OFF_W-1:0] CNT_EN_OFF = 'h8;

  logic [OFF_W-1:0]   off;
  soc_pkg::soc_data_t exit_q, cnt_en_q, rdata_q;
  logic               valid_q;

  // Window is 4 KiB aligned, so the low bits are the offset
  assign off = req_i.addr[OFF_W-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
      if (req_i.valid && req_i.we) begin
        if (off == EXIT_OFF) exit_q <= soc_pkg::merge_bytes(exit_q, req_i.wdata, req_i.be);
        if (off == CNT_EN_OFF) begin
          cnt_en_q <= soc_pkg::merge_bytes(cnt_en_q, req_i.wdata, req_i.be);
        end
      end
    end
  end

  // Read mux, writes return zero
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      if (req_i.we) rdata_q <= '0;
      else if (off == EXIT_OFF) rdata_q <= exit_q;
      else if (off == CNT_EN_OFF) rdata_q <= cnt_en_q;
      else rdata_q <= '0;
    end
  end

  assign rsp_o.valid = valid_q;
  assign rsp_o.rdata = rdata_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule

//--- verilog/l2_sram.sv
// L2 memory of L2_WORDS 64-bit words with byte-enabled writes.
// Read data and response valid come one cycle after the request;
// writes answer with zero data.

`timescale 1ns/1ps
`include "soc_settings.svh"

module l2_sram (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  soc_pkg::soc_req_t req_i,
  output soc_pkg::soc_rsp_t rsp_o
);

  localparam int unsigned IDX_W = $clog2(`L2_WORDS);
  localparam int unsigned OFF_W = $clog2(`SOC_STRB_W);

  soc_pkg::soc_data_t mem [`L2_WORDS];
  soc_pkg::soc_data_t rdata_q;
  logic [IDX_W-1:0]   idx;
  logic               valid_q;

  // Word offset inside the window
  assign idx = req_i.addr[OFF_W +: IDX_W];

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      if (req_i.we) begin
        for (int i = 0; i < `SOC_STRB_W; i++) begin
          if (req_i.be[i]) mem[idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
    end
  end

  assign rsp_o.valid = valid_q;
  assign rsp_o.rdata = rdata_q;

  // Router decode keeps every valid access inside the memory
  a_idx_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_i.valid |-> ((req_i.addr - soc_pkg::soc_addr_t'(`L2_BASE)) >> OFF_W) < `L2_WORDS
  );

endmodule

//--- verilog/soc_router.sv
// Address decoder between the SBA port and the targets.
// Steers each request to the L2, the control registers or the debug
// window, and merges the one-cycle responses back onto the bus.
// Unmapped accesses complete normally: reads give zero, writes are dropped.

`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_router (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  soc_pkg::soc_req_t  bus_req_i,
  output soc_pkg::soc_rsp_t  bus_rsp_o,
  // Targets
  output soc_pkg::soc_req_t  l2_req_o,
  output soc_pkg::soc_req_t  ctrl_req_o,
  input  soc_pkg::soc_rsp_t  l2_rsp_i,
  input  soc_pkg::soc_rsp_t  ctrl_rsp_i,
  // Debug window towards the external debug module
  output logic               dm_device_req_o,
  output logic               dm_device_we_o,
  output soc_pkg::soc_addr_t dm_device_addr_o,
  output soc_pkg::soc_strb_t dm_device_be_o,
  output soc_pkg::soc_data_t dm_device_wdata_o,
  input  soc_pkg::soc_data_t dm_device_rdata_i
);

  soc_pkg::soc_addr_t    l2_off, ctrl_off, dbg_off;
  soc_pkg::soc_target_e  tgt, tgt_q;
  logic                  dbg_vld_q, dbg_rd_q, none_vld_q;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  assign l2_off   = bus_req_i.addr - soc_pkg::soc_addr_t'(`L2_BASE);
  assign ctrl_off = bus_req_i.addr - soc_pkg::soc_addr_t'(`CTRL_BASE);
  assign dbg_off  = bus_req_i.addr - soc_pkg::soc_addr_t'(`DBG_BASE);

  always_comb begin
    if (l2_off < soc_pkg::soc_addr_t'(`L2_LEN)) tgt = soc_pkg::TGT_L2;
    else if (ctrl_off < soc_pkg::soc_addr_t'(`CTRL_LEN)) tgt = soc_pkg::TGT_CTRL;
    else if (dbg_off < soc_pkg::soc_addr_t'(`DBG_LEN)) tgt = soc_pkg::TGT_DEBUG;
    else tgt = soc_pkg::TGT_NONE;
  end

  // Each target sees valid only inside its own window
  always_comb begin
    l2_req_o         = bus_req_i;
    l2_req_o.valid   = bus_req_i.valid && (tgt == soc_pkg::TGT_L2);
    ctrl_req_o       = bus_req_i;
    ctrl_req_o.valid = bus_req_i.valid && (tgt == soc_pkg::TGT_CTRL);
  end

  // Debug window port
  assign dm_device_req_o   = bus_req_i.valid && (tgt == soc_pkg::TGT_DEBUG);
  assign dm_device_we_o    = bus_req_i.we;
  assign dm_device_addr_o  = bus_req_i.addr;
  assign dm_device_be_o    = bus_req_i.be;
  assign dm_device_wdata_o = bus_req_i.wdata;

  ////////////////////////////////////////
  // Response path
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tgt_q      <= soc_pkg::TGT_NONE;
      dbg_vld_q  <= 1'b0;
      dbg_rd_q   <= 1'b0;
      none_vld_q <= 1'b0;
    end else begin
      if (bus_req_i.valid) tgt_q <= tgt;
      dbg_vld_q  <= dm_device_req_o;
      dbg_rd_q   <= dm_device_req_o && !bus_req_i.we;
      none_vld_q <= bus_req_i.valid && (tgt == soc_pkg::TGT_NONE);
    end
  end

  always_comb begin
    unique case (tgt_q)
      soc_pkg::TGT_L2:   bus_rsp_o = l2_rsp_i;
      soc_pkg::TGT_CTRL: bus_rsp_o = ctrl_rsp_i;
      soc_pkg::TGT_DEBUG: begin
        bus_rsp_o.valid = dbg_vld_q;
        bus_rsp_o.rdata = dbg_rd_q ? dm_device_rdata_i : '0;
      end
      default: begin
        bus_rsp_o.valid = none_vld_q;
        bus_rsp_o.rdata = '0;
      end
    endcase
  end

  // Only the addressed target may answer
  a_one_rsp : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0({l2_rsp_i.valid, ctrl_rsp_i.valid, dbg_vld_q, none_vld_q})
  );

endmodule

//--- verilog/sba_port.sv
// SBA front end for the external debug module.
// Grants and latches one request while idle, issues it on the internal
// bus for one cycle and forwards the single response pulse back.
// Grant to r_valid is always two cycles.

`timescale 1ns/1ps
`include "soc_settings.svh"

module sba_port (
  input  logic                clk_i,
  input  logic                rst_ni,
  // SBA host side
  input  logic                sba_req_i,
  input  logic                sba_we_i,
  input  soc_pkg::soc_addr_t  sba_addr_i,
  input  soc_pkg::soc_strb_t  sba_be_i,
  input  soc_pkg::soc_data_t  sba_wdata_i,
  output logic                sba_gnt_o,
  output logic                sba_r_valid_o,
  output soc_pkg::soc_data_t  sba_r_rdata_o,
  // Internal bus
  output soc_pkg::soc_req_t   bus_req_o,
  input  soc_pkg::soc_rsp_t   bus_rsp_i
);

  typedef enum logic [1:0] {
    SBA_IDLE,
    SBA_ISSUE,
    SBA_WAIT
  } sba_state_e;

  sba_state_e        state_d, state_q;
  soc_pkg::soc_req_t req_q;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    sba_gnt_o = 1'b0;
    unique case (state_q)
      SBA_IDLE: begin
        if (sba_req_i) begin
          sba_gnt_o = 1'b1;
          state_d   = SBA_ISSUE;
        end
      end
      SBA_ISSUE: begin
        state_d = SBA_WAIT;
      end
      SBA_WAIT: begin
        // Targets answer exactly one cycle after the issue
        if (bus_rsp_i.valid) state_d = SBA_IDLE;
      end
      default: begin
        state_d = SBA_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SBA_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload, captured at grant
  always_ff @(posedge clk_i) begin
    if (sba_gnt_o) begin
      req_q <= '{valid: 1'b1, we: sba_we_i, addr: sba_addr_i, be: sba_be_i,
                 wdata: sba_wdata_i};
    end
  end

  ////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////

  always_comb begin
    bus_req_o       = req_q;
    bus_req_o.valid = (state_q == SBA_ISSUE);
  end

  assign sba_r_valid_o = (state_q == SBA_WAIT) && bus_rsp_i.valid;
  assign sba_r_rdata_o = bus_rsp_i.rdata;

  // No grant while busy, and the response lands two cycles after the grant
  a_gnt_idle_only : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    sba_gnt_o |=> !sba_gnt_o ##1 (!sba_gnt_o && sba_r_valid_o)
  );

endmodule

//--- verilog/soc_pkg.sv
// Shared types of the SBA memory subsystem.
// Request and response structs travel between the SBA port, the router
// and the targets; the target enum is the router's decode result.

`include "soc_settings.svh"

package soc_pkg;

  typedef logic [`SOC_ADDR_W-1:0] soc_addr_t;
  typedef logic [`SOC_DATA_W-1:0] soc_data_t;
  typedef logic [`SOC_STRB_W-1:0] soc_strb_t;

  // Single-beat request, valid is a one-cycle pulse
  typedef struct packed {
    logic      valid;
    logic      we;
    soc_addr_t addr;
    soc_strb_t be;
    soc_data_t wdata;
  } soc_req_t;

  // One response pulse per request, rdata is zero for writes
  typedef struct packed {
    logic      valid;
    soc_data_t rdata;
  } soc_rsp_t;

  typedef enum logic [1:0] {
    TGT_L2,
    TGT_CTRL,
    TGT_DEBUG,
    TGT_NONE
  } soc_target_e;

  // Byte-enabled update of a data word
  function automatic soc_data_t merge_bytes(soc_data_t old_d, soc_data_t new_d, soc_strb_t be);
    soc_data_t res;
    res = old_d;
    for (int i = 0; i < `SOC_STRB_W; i++) begin
      if (be[i]) res[8*i +: 8] = new_d[8*i +: 8];
    end
    return res;
  endfunction

endpackage

//--- verilog/soc_settings.svh
// Widths, memory map and L2 size of the SBA memory subsystem.
// Included by the package and by every RTL module that needs them.

`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_STRB_W 8

// L2 memory, 128 words of 64 bits
`define L2_WORDS 128
`define L2_BASE  32'h8000_0000
`define L2_LEN   32'h0000_0400

// Control registers and debug window keep 4 KiB each
`define CTRL_BASE 32'hD000_0000
`define CTRL_LEN  32'h0000_1000
`define DBG_BASE  32'h1A11_0000
`define DBG_LEN   32'h0000_1000

`endif
